//--- source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// First fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_0000

// Log2 of the instruction cache size in bytes, 8 gives 64 one-word lines
`define CPU_ICACHE_SIZE 8

// RV32 major opcodes, integer
`define CPU_OPC_LOAD     7'b0000011
`define CPU_OPC_OP_IMM   7'b0010011
`define CPU_OPC_AUIPC    7'b0010111
`define CPU_OPC_STORE    7'b0100011
`define CPU_OPC_OP       7'b0110011
`define CPU_OPC_LUI      7'b0110111

// Float loads, stores, fused ops and arithmetic
`define CPU_OPC_LOAD_FP  7'b0000111
`define CPU_OPC_STORE_FP 7'b0100111
`define CPU_OPC_FMADD    7'b1000011
`define CPU_OPC_FMSUB    7'b1000111
`define CPU_OPC_FNMSUB   7'b1001011
`define CPU_OPC_FNMADD   7'b1001111
`define CPU_OPC_OP_FP    7'b1010011

// Control flow and system
`define CPU_OPC_BRANCH   7'b1100011
`define CPU_OPC_JALR     7'b1100111
`define CPU_OPC_JAL      7'b1101111
`define CPU_OPC_SYSTEM   7'b1110011

`endif

//--- source/cpu_pkg.sv
package cpu_pkg;

	// Byte address on the fetch side and on the memory bus
	typedef logic [31:0] addr_t;

	// One instruction word as stored in the cache
	typedef logic [31:0] word_t;

	// Register index with bank select in the top bit
	// Bank 0 is the integer file, bank 1 the float file
	typedef logic [5:0] register_t;

	// Sequence tag, wraps around
	// Decode sees a new instruction whenever this changes
	typedef logic [7:0] tag_t;

	// Fetch sequencing
	typedef enum logic {
		wait_icache,
		wait_jump
	} fetch_state_t;

endpackage

//--- source/cpu_icache.sv
`include "cpu_defines.svh"

module cpu_icache #(
	parameter int SIZE = `CPU_ICACHE_SIZE
) (
	input  logic           i_clock,
	input  logic           i_reset,

	// Lookup from fetch
	input  cpu_pkg::addr_t i_pc,
	input  logic           i_stall,
	output cpu_pkg::word_t o_rdata,
	output logic           o_ready,

	// Refill bus
	output logic           o_bus_request,
	output cpu_pkg::addr_t o_bus_address,
	input  logic           i_bus_ready,
	input  cpu_pkg::word_t i_bus_rdata
);
	import cpu_pkg::*;

	localparam int INDEX_BITS = SIZE - 2;
	localparam int TAG_BITS = 32 - SIZE;
	localparam int LINES = 2 ** INDEX_BITS;

	typedef enum logic {
		refill_idle,
		refill_busy
	} refill_state_t;

	// Line storage, one word per line
	word_t               data_mem [LINES];
	logic [TAG_BITS-1:0] tag_mem [LINES];
	logic [LINES-1:0]    valid;

	refill_state_t refill_state;
	addr_t         refill_address;

	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_BITS-1:0]   pc_tag;
	logic [INDEX_BITS-1:0] refill_index;
	logic [TAG_BITS-1:0]   refill_tag;
	logic                  hit;
	logic                  fill;

	assign pc_index = i_pc[SIZE-1:2];
	assign pc_tag = i_pc[31:SIZE];
	assign refill_index = refill_address[SIZE-1:2];
	assign refill_tag = refill_address[31:SIZE];

	// Lookup is purely combinational on the current PC
	assign hit = valid[pc_index] && (tag_mem[pc_index] == pc_tag);
	assign o_rdata = data_mem[pc_index];
	assign o_ready = hit && !i_stall;

	// Memory word arrives on this edge
	assign fill = (refill_state == refill_busy) && i_bus_ready;

	// Request is held for the whole refill and drops after the ready pulse
	assign o_bus_request = (refill_state == refill_busy);
	assign o_bus_address = refill_address;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refill_state <= refill_idle;
			valid <= '0;
		end else begin
			case (refill_state)
				refill_idle: begin
					// Stall does not block this, so a jump target
					// gets prefetched while decode is busy
					if (!hit) begin
						refill_state <= refill_busy;
					end
				end
				refill_busy: begin
					if (i_bus_ready) begin
						valid[refill_index] <= 1'b1;
						refill_state <= refill_idle;
					end
				end
			endcase
		end
	end

	// Miss address, word aligned
	always_ff @(posedge i_clock) begin
		if (refill_state == refill_idle && !hit) begin
			refill_address <= {i_pc[31:2], 2'b00};
		end
	end

	always_ff @(posedge i_clock) begin
		if (fill) begin
			data_mem[refill_index] <= i_bus_rdata;
			tag_mem[refill_index] <= refill_tag;
		end
	end

endmodule

//--- source/cpu_predecode.sv
`include "cpu_defines.svh"

module cpu_predecode (
	input  cpu_pkg::word_t     i_instruction,
	output cpu_pkg::register_t o_rs1,
	output cpu_pkg::register_t o_rs2,
	output cpu_pkg::register_t o_rs3,
	output cpu_pkg::register_t o_rd,
	output logic               o_control_flow
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// Format classes
	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_r4;
	logic is_system;

	// Opcodes that matter for bank selection or control flow
	logic is_load_fp;
	logic is_store_fp;
	logic is_op_fp;
	logic is_jalr;

	logic have_rs1;
	logic have_rs2;
	logic have_rs3;
	logic have_rd;
	logic rs1_float;
	logic rs2_float;
	logic rd_float;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	always_comb begin
		is_r = 1'b0;
		is_i = 1'b0;
		is_s = 1'b0;
		is_b = 1'b0;
		is_u = 1'b0;
		is_j = 1'b0;
		is_r4 = 1'b0;
		is_system = 1'b0;
		is_load_fp = 1'b0;
		is_store_fp = 1'b0;
		is_op_fp = 1'b0;
		is_jalr = 1'b0;
		case (opcode)
			`CPU_OPC_LOAD, `CPU_OPC_OP_IMM: is_i = 1'b1;
			`CPU_OPC_LOAD_FP: begin
				is_i = 1'b1;
				is_load_fp = 1'b1;
			end
			`CPU_OPC_JALR: begin
				is_i = 1'b1;
				is_jalr = 1'b1;
			end
			`CPU_OPC_STORE: is_s = 1'b1;
			`CPU_OPC_STORE_FP: begin
				is_s = 1'b1;
				is_store_fp = 1'b1;
			end
			`CPU_OPC_OP: is_r = 1'b1;
			`CPU_OPC_OP_FP: begin
				is_r = 1'b1;
				is_op_fp = 1'b1;
			end
			`CPU_OPC_FMADD, `CPU_OPC_FMSUB, `CPU_OPC_FNMSUB, `CPU_OPC_FNMADD: is_r4 = 1'b1;
			`CPU_OPC_BRANCH: is_b = 1'b1;
			`CPU_OPC_LUI, `CPU_OPC_AUIPC: is_u = 1'b1;
			`CPU_OPC_JAL: is_j = 1'b1;
			`CPU_OPC_SYSTEM: begin
				is_system = 1'b1;
				// CSR access behaves like I-format
				is_i = (funct3 != 3'b000);
			end
			default: ;
		endcase
	end

	assign have_rs1 = is_b | is_i | is_r | is_s | is_r4;
	assign have_rs2 = is_b | is_r | is_s | is_r4;
	assign have_rs3 = is_r4;
	assign have_rd = is_i | is_j | is_r | is_u | is_r4;

	// FCVT.W, FMV.X.W, FCLASS and compares write the integer file
	assign rd_float = is_load_fp | is_r4 |
		(is_op_fp && !(funct7 inside {7'b1110000, 7'b1010000, 7'b1100000}));
	// FCVT.S.W and FMV.W.X read an integer source
	assign rs1_float = is_r4 | (is_op_fp && !(funct7 inside {7'b1101000, 7'b1111000}));
	assign rs2_float = is_store_fp | is_op_fp | is_r4;

	assign o_rs1 = have_rs1 ? {rs1_float, i_instruction[19:15]} : '0;
	assign o_rs2 = have_rs2 ? {rs2_float, i_instruction[24:20]} : '0;
	assign o_rs3 = have_rs3 ? {1'b1, i_instruction[31:27]} : '0;
	assign o_rd = have_rd ? {rd_float, i_instruction[11:7]} : '0;

	// ECALL, MRET and WFI all wait for execute like a jump
	assign o_control_flow = is_j | is_jalr | is_b | (is_system && funct3 == 3'b000);

endmodule

//--- source/cpu_fetch.sv
`include "cpu_defines.svh"

module cpu_fetch (
	input  logic               i_clock,
	input  logic               i_reset,

	// Jump request from execute
	input  logic               i_jump,
	input  cpu_pkg::addr_t     i_jump_pc,

	// Interrupt
	input  logic               i_irq_pending,
	input  cpu_pkg::addr_t     i_irq_pc,
	output logic               o_irq_dispatched,
	output cpu_pkg::addr_t     o_irq_epc,

	// Memory bus
	output logic               o_bus_request,
	input  logic               i_bus_ready,
	output cpu_pkg::addr_t     o_bus_address,
	input  cpu_pkg::word_t     i_bus_rdata,

	// To decode
	input  logic               i_decode_busy,
	output cpu_pkg::tag_t      o_tag,
	output cpu_pkg::addr_t     o_pc,
	output cpu_pkg::word_t     o_instruction,
	output cpu_pkg::register_t o_rs1,
	output cpu_pkg::register_t o_rs2,
	output cpu_pkg::register_t o_rs3,
	output cpu_pkg::register_t o_rd
);
	import cpu_pkg::*;

	fetch_state_t state;
	addr_t        pc;

	word_t icache_rdata;
	logic  icache_ready;
	logic  icache_stall;

	register_t pre_rs1;
	register_t pre_rs2;
	register_t pre_rs3;
	register_t pre_rd;
	logic      pre_control_flow;

	logic accept;
	logic irq_dispatch;

	cpu_icache #(
		.SIZE(`CPU_ICACHE_SIZE)
	) cpu_icache_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(icache_stall),
		.o_rdata(icache_rdata),
		.o_ready(icache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Register indices are ready early so the register file can be read
	// while decode works on the rest of the word
	cpu_predecode cpu_predecode_inst (
		.i_instruction(icache_rdata),
		.o_rs1(pre_rs1),
		.o_rs2(pre_rs2),
		.o_rs3(pre_rs3),
		.o_rd(pre_rd),
		.o_control_flow(pre_control_flow)
	);

	assign icache_stall = i_decode_busy || (state != wait_icache);

	// Cache ready already implies wait_icache and no back-pressure
	assign accept = icache_ready && !i_irq_pending;
	assign irq_dispatch = (state == wait_icache) && i_irq_pending && !o_irq_dispatched;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= wait_icache;
			pc <= `CPU_RESET_VECTOR;
			o_tag <= '0;
			o_irq_dispatched <= 1'b0;
		end else begin
			case (state)
				wait_icache: begin
					// Interrupts are only taken here, so a pending
					// branch always resolves first
					if (i_irq_pending) begin
						if (!o_irq_dispatched) begin
							o_irq_dispatched <= 1'b1;
							pc <= i_irq_pc;
						end
					end else begin
						o_irq_dispatched <= 1'b0;
						if (accept) begin
							o_tag <= o_tag + tag_t'(1);
							if (pre_control_flow) begin
								// Hold until execute says where to go
								state <= wait_jump;
							end else begin
								pc <= pc + addr_t'(4);
							end
						end
					end
				end
				wait_jump: begin
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= wait_icache;
					end
				end
			endcase
		end
	end

	// Instruction payload and return address
	always_ff @(posedge i_clock) begin
		if (irq_dispatch) begin
			o_irq_epc <= pc;
		end
		if (accept) begin
			o_pc <= pc;
			o_instruction <= icache_rdata;
			o_rs1 <= pre_rs1;
			o_rs2 <= pre_rs2;
			o_rs3 <= pre_rs3;
			o_rd <= pre_rd;
		end
	end

endmodule

//--- test/fetch_checker.sv
`include "cpu_defines.svh"

module fetch_checker (
	input  logic               i_clock,
	input  logic               i_reset,
	input  cpu_pkg::tag_t      i_tag,
	input  cpu_pkg::addr_t     i_pc,
	input  cpu_pkg::word_t     i_instruction,
	input  cpu_pkg::register_t i_rs1,
	input  cpu_pkg::register_t i_rs2,
	input  cpu_pkg::register_t i_rs3,
	input  cpu_pkg::register_t i_rd,
	input  cpu_pkg::addr_t     i_expected_pc,
	input  cpu_pkg::word_t     i_expected_instruction,
	output int                 o_checks,
	output int                 o_errors
);
	import cpu_pkg::*;

	tag_t last_tag;

	// Register indices with bank bits, straight from the RV32F register usage
	function automatic void expected_indices(input word_t w, output register_t rs1,
			output register_t rs2, output register_t rs3, output register_t rd);
		logic [6:0] f7;
		f7 = w[31:25];
		rs1 = '0;
		rs2 = '0;
		rs3 = '0;
		rd = '0;
		case (w[6:0])
			`CPU_OPC_LOAD, `CPU_OPC_OP_IMM, `CPU_OPC_JALR: begin
				rs1 = {1'b0, w[19:15]};
				rd = {1'b0, w[11:7]};
			end
			`CPU_OPC_LOAD_FP: begin
				rs1 = {1'b0, w[19:15]};
				rd = {1'b1, w[11:7]};
			end
			`CPU_OPC_STORE, `CPU_OPC_BRANCH: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b0, w[24:20]};
			end
			`CPU_OPC_STORE_FP: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b1, w[24:20]};
			end
			`CPU_OPC_OP: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b0, w[24:20]};
				rd = {1'b0, w[11:7]};
			end
			`CPU_OPC_OP_FP: begin
				rs1 = {!(f7 == 7'b1101000 || f7 == 7'b1111000), w[19:15]};
				rs2 = {1'b1, w[24:20]};
				rd = {!(f7 == 7'b1110000 || f7 == 7'b1010000 || f7 == 7'b1100000), w[11:7]};
			end
			`CPU_OPC_FMADD, `CPU_OPC_FMSUB, `CPU_OPC_FNMSUB, `CPU_OPC_FNMADD: begin
				rs1 = {1'b1, w[19:15]};
				rs2 = {1'b1, w[24:20]};
				rs3 = {1'b1, w[31:27]};
				rd = {1'b1, w[11:7]};
			end
			`CPU_OPC_LUI, `CPU_OPC_AUIPC, `CPU_OPC_JAL: rd = {1'b0, w[11:7]};
			`CPU_OPC_SYSTEM: begin
				if (w[14:12] != 3'b000) begin
					rs1 = {1'b0, w[19:15]};
					rd = {1'b0, w[11:7]};
				end
			end
			default: ;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp,
			inout int bad);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			bad = bad + 1;
		end
	endtask

	initial begin
		o_checks = 0;
		o_errors = 0;
		last_tag = '0;
	end

	// Outputs settle well before posedge + 2
	always @(posedge i_clock) begin
		register_t e_rs1;
		register_t e_rs2;
		register_t e_rs3;
		register_t e_rd;
		int bad;
		#2;
		if (i_reset) begin
			last_tag = '0;
		end else if (i_tag !== last_tag) begin
			bad = 0;
			expected_indices(i_expected_instruction, e_rs1, e_rs2, e_rs3, e_rd);
			compare("o_tag", 32'(i_tag), 32'(last_tag + tag_t'(1)), bad);
			compare("o_pc", i_pc, i_expected_pc, bad);
			compare("o_instruction", i_instruction, i_expected_instruction, bad);
			compare("o_rs1", 32'(i_rs1), 32'(e_rs1), bad);
			compare("o_rs2", 32'(i_rs2), 32'(e_rs2), bad);
			compare("o_rs3", 32'(i_rs3), 32'(e_rs3), bad);
			compare("o_rd", 32'(i_rd), 32'(e_rd), bad);
			o_checks = o_checks + 1;
			o_errors = o_errors + bad;
			$display("test %0d pc %h instruction %h: %s", o_checks, i_pc, i_instruction,
				(bad == 0) ? "pass" : "fail");
			last_tag = i_tag;
		end
	end

endmodule

//--- test/tb_cpu_fetch.sv
`include "cpu_defines.svh"

module tb_cpu_fetch;
	import cpu_pkg::*;

	localparam int STEPS = 20;
	localparam int TIMEOUT = 50;
	localparam int IDLE = 8;

	// Row actions
	localparam int NONE = 0;
	localparam int JUMP = 1;
	localparam int IRQ = 2;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	addr_t i_jump_pc;
	logic i_irq_pending;
	addr_t i_irq_pc;
	logic o_irq_dispatched;
	addr_t o_irq_epc;
	logic o_bus_request;
	logic i_bus_ready;
	addr_t o_bus_address;
	word_t i_bus_rdata;
	logic i_decode_busy;
	tag_t o_tag;
	addr_t o_pc;
	word_t o_instruction;
	register_t o_rs1;
	register_t o_rs2;
	register_t o_rs3;
	register_t o_rd;

	addr_t expected_pc;
	word_t expected_instruction;
	int checks;
	int checker_errors;
	int tb_errors;

	// Stimulus table
	addr_t row_pc [STEPS];
	word_t row_instruction [STEPS];
	int row_action [STEPS];
	addr_t row_target [STEPS];
	int row_busy [STEPS];
	bit row_hit [STEPS];

	word_t memory [256];
	logic [31:0] lfsr;

	cpu_fetch cpu_fetch_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_tag(o_tag),
		.o_pc(o_pc),
		.o_instruction(o_instruction),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_rs3(o_rs3),
		.o_rd(o_rd)
	);

	fetch_checker fetch_checker_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tag(o_tag),
		.i_pc(o_pc),
		.i_instruction(o_instruction),
		.i_rs1(o_rs1),
		.i_rs2(o_rs2),
		.i_rs3(o_rs3),
		.i_rd(o_rd),
		.i_expected_pc(expected_pc),
		.i_expected_instruction(expected_instruction),
		.o_checks(checks),
		.o_errors(checker_errors)
	);

	initial begin
		i_clock = 1'b0;
		forever begin
			#20 i_clock = ~i_clock;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
			input int rd, input logic [6:0] op);
		return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), op};
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic word_t enc_r4(input int rs3, input int rs2, input int rs1,
			input int rd, input logic [6:0] op);
		return {5'(rs3), 2'b00, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), op};
	endfunction

	task automatic set_row(input int i, input addr_t pc, input word_t w, input int action,
			input addr_t target, input int busy, input bit hit);
		row_pc[i] = pc;
		row_instruction[i] = w;
		row_action[i] = action;
		row_target[i] = target;
		row_busy[i] = busy;
		row_hit[i] = hit;
	endtask

	// Bus memory with 1 to 4 cycles of latency
	initial begin
		logic [1:0] bits;
		int delay;
		addr_t request_address;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		forever begin
			@(posedge i_clock);
			#1;
			if (o_bus_request && !i_reset) begin
				request_address = o_bus_address;
				if (request_address[1:0] != 2'b00 || request_address[31:10] != '0) begin
					report("bus address outside the program memory or not word aligned");
				end
				lfsr = lfsr_step(lfsr);
				bits[0] = lfsr[0];
				lfsr = lfsr_step(lfsr);
				bits[1] = lfsr[0];
				delay = int'(bits) + 1;
				repeat (delay - 1) @(posedge i_clock);
				#1;
				// Address must not move while the request is outstanding
				if (o_bus_address !== request_address) begin
					$display("mismatch o_bus_address: got %h expected %h", o_bus_address,
						request_address);
					tb_errors = tb_errors + 1;
				end
				i_bus_ready = 1'b1;
				i_bus_rdata = memory[o_bus_address[9:2]];
				@(posedge i_clock);
				#1;
				i_bus_ready = 1'b0;
			end
		end
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic report(input string what);
		$display("%s", what);
		tb_errors = tb_errors + 1;
	endtask

	// Returns at posedge + 3, after the checker has looked
	task automatic wait_for_tag(input tag_t prev, input bit no_request);
		int n;
		bit seen_request;
		n = 0;
		seen_request = 0;
		while (o_tag == prev) begin
			if (n == TIMEOUT) begin
				fail_now("timeout waiting for tag change");
			end
			@(posedge i_clock);
			#3;
			if (no_request && o_bus_request && !seen_request) begin
				report("bus request raised while fetching cached code");
				seen_request = 1;
			end
			n = n + 1;
		end
	endtask

	task automatic hold_and_check(input int cycles, input tag_t tag);
		addr_t held_pc;
		word_t held_instruction;
		held_pc = o_pc;
		held_instruction = o_instruction;
		repeat (cycles) begin
			@(posedge i_clock);
			#3;
			if (o_tag !== tag) begin
				report("tag changed while fetch should be holding");
			end
			if (o_pc !== held_pc) begin
				$display("mismatch o_pc: got %h expected %h", o_pc, held_pc);
				tb_errors = tb_errors + 1;
			end
			if (o_instruction !== held_instruction) begin
				$display("mismatch o_instruction: got %h expected %h", o_instruction,
					held_instruction);
				tb_errors = tb_errors + 1;
			end
		end
	endtask

	task automatic wait_for_dispatch();
		int n;
		n = 0;
		while (!o_irq_dispatched) begin
			if (n == TIMEOUT) begin
				fail_now("timeout waiting for interrupt dispatch");
			end
			@(posedge i_clock);
			#3;
			n = n + 1;
		end
	endtask

	initial begin
		tag_t prev;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_decode_busy = 1'b0;
		expected_pc = '0;
		expected_instruction = '0;
		tb_errors = 0;
		lfsr = 32'hece202f4;

		set_row(0, 32'h00, enc_i(5, 2, 3'b000, 1, `CPU_OPC_OP_IMM), NONE, 0, 0, 0);
		set_row(1, 32'h04, enc_r(7'h00, 5, 4, 3, `CPU_OPC_OP), NONE, 0, 0, 0);
		set_row(2, 32'h08, enc_i(8, 7, 3'b010, 6, `CPU_OPC_LOAD_FP), NONE, 0, 0, 0);
		set_row(3, 32'h0c, {7'h00, 5'd8, 5'd9, 3'b010, 5'd12, `CPU_OPC_STORE_FP},
			NONE, 0, 0, 0);
		set_row(4, 32'h10, enc_r(7'b0000000, 12, 11, 10, `CPU_OPC_OP_FP), NONE, 0, 6, 0);
		set_row(5, 32'h14, enc_r(7'b1100000, 0, 14, 13, `CPU_OPC_OP_FP), NONE, 0, 0, 0);
		set_row(6, 32'h18, enc_r(7'b1101000, 0, 16, 15, `CPU_OPC_OP_FP), NONE, 0, 0, 0);
		set_row(7, 32'h1c, enc_r4(20, 19, 18, 17, `CPU_OPC_FMADD), NONE, 0, 0, 0);
		set_row(8, 32'h20, enc_i(12'h300, 22, 3'b010, 21, `CPU_OPC_SYSTEM), NONE, 0, 0, 0);
		set_row(9, 32'h24, {20'h12345, 5'd23, `CPU_OPC_LUI}, NONE, 0, 0, 0);
		set_row(10, 32'h28, {20'h01800, 5'd1, `CPU_OPC_JAL}, JUMP, 32'h40, 0, 0);
		set_row(11, 32'h40, enc_r(7'b1110000, 0, 25, 24, `CPU_OPC_OP_FP), NONE, 0, 6, 0);
		set_row(12, 32'h44, {7'h00, 5'd27, 5'd26, 3'b000, 5'd8, `CPU_OPC_BRANCH},
			JUMP, 32'h08, 0, 0);
		// Back into code that is already cached
		set_row(13, 32'h08, row_instruction[2], NONE, 0, 0, 1);
		set_row(14, 32'h0c, row_instruction[3], NONE, 0, 2, 1);
		set_row(15, 32'h10, row_instruction[4], IRQ, 32'h100, 0, 1);
		// Vector aliases line 0 with a different tag
		set_row(16, 32'h100, enc_r4(3, 2, 1, 4, `CPU_OPC_FNMSUB), NONE, 0, 0, 0);
		set_row(17, 32'h104, enc_i(0, 0, 3'b000, 0, `CPU_OPC_SYSTEM), JUMP, 32'h48, 0, 0);
		set_row(18, 32'h48, enc_r(7'b0010100, 30, 29, 28, `CPU_OPC_OP_FP), NONE, 0, 0, 0);
		set_row(19, 32'h4c, enc_r(7'b1111000, 0, 31, 5, `CPU_OPC_OP_FP), NONE, 0, 0, 0);

		for (int a = 0; a < 256; a++) begin
			memory[a] = (32'(a) << 2) ^ 32'hc3a5_0000;
		end
		for (int i = 0; i < STEPS; i++) begin
			memory[row_pc[i][9:2]] = row_instruction[i];
		end

		repeat (4) @(posedge i_clock);
		#3;
		i_reset = 1'b0;
		if (o_bus_request || o_irq_dispatched || o_tag !== 8'h00) begin
			report("outputs not in their reset state");
		end

		prev = o_tag;
		for (int i = 0; i < STEPS; i++) begin
			expected_pc = row_pc[i];
			expected_instruction = row_instruction[i];
			if (row_busy[i] > 0) begin
				i_decode_busy = 1'b1;
				hold_and_check(row_busy[i], prev);
				i_decode_busy = 1'b0;
			end
			wait_for_tag(prev, row_hit[i]);
			prev = o_tag;
			// Any accepted instruction means no interrupt is pending
			if (o_irq_dispatched) begin
				report("interrupt dispatch still set after fetch resumed");
			end
			if (row_action[i] == JUMP) begin
				hold_and_check(IDLE, prev);
				i_jump = 1'b1;
				i_jump_pc = row_target[i];
				@(posedge i_clock);
				#3;
				i_jump = 1'b0;
			end else if (row_action[i] == IRQ) begin
				i_irq_pending = 1'b1;
				i_irq_pc = row_target[i];
				wait_for_dispatch();
				if (o_irq_epc !== row_pc[i] + 32'd4) begin
					$display("mismatch o_irq_epc: got %h expected %h", o_irq_epc,
						row_pc[i] + 32'd4);
					tb_errors = tb_errors + 1;
				end
				hold_and_check(IDLE, prev);
				i_irq_pending = 1'b0;
			end
		end

		$display("checks %0d, checker errors %0d, testbench errors %0d", checks,
			checker_errors, tb_errors);
		if (checker_errors == 0 && tb_errors == 0 && checks == STEPS) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+source
source/cpu_pkg.sv
source/cpu_icache.sv
source/cpu_predecode.sv
source/cpu_fetch.sv
test/fetch_checker.sv
test/tb_cpu_fetch.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_cpu_fetch
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
